//--- files.f
+incdir+include
logic/tomasulo_pkg.sv
logic/reservation_station.sv
logic/exec_alu.sv
logic/load_store_unit.sv
logic/issue_cluster.sv
testbench/issue_cluster_props.sv
testbench/issue_cluster_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps -f files.f \
    --top-module issue_cluster_tb -Mdir obj_dir

out="$(./obj_dir/Vissue_cluster_tb || true)"
echo "$out"
if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

//--- testbench/issue_cluster_tb.sv
`timescale 1ns/100ps
`include "tomasulo_cfg.svh"

module issue_cluster_tb;
    localparam int XLEN      = `TOMASULO_XLEN;
    localparam int TAG_W     = `TOMASULO_TAG_W;
    localparam int NTAGS     = 1 << TAG_W;
    localparam int N_ALU     = 60;
    localparam int N_CHAIN   = 60;
    localparam int N_MEM     = 40;
    localparam int N_BURST   = 4;
    localparam int BURST_LEN = 8;
    localparam int N_OPS     = N_ALU + N_CHAIN + 2 * N_MEM + N_BURST * (BURST_LEN + 1);
    localparam int LIMIT     = 5 * 200 + N_OPS * 12;

    logic                 clk;
    logic                 rst;
    tomasulo_pkg::rv_op_e op;
    logic [TAG_W-1:0]     des_in;
    logic [XLEN-1:0]      value1;
    logic [XLEN-1:0]      value2;
    logic [XLEN-1:0]      imm_in;
    logic [TAG_W-1:0]     query1;
    logic [TAG_W-1:0]     query2;
    logic                 rs_full;
    logic [TAG_W-1:0]     alu_des;
    logic [XLEN-1:0]      alu_data;
    logic [TAG_W-1:0]     memory_des;
    logic [XLEN-1:0]      memory_data;

    logic [31:0]          seed;
    int                   cycle;
    bit                   pend [NTAGS];
    logic [XLEN-1:0]      val  [NTAGS]; // expected result, kept after the broadcast.
    int                   due  [NTAGS]; // arrival cycle, -1 when not timed.
    logic [TAG_W-1:0]     bus_alu;
    logic [TAG_W-1:0]     bus_mem;
    logic [XLEN-1:0]      shadow [`TOMASULO_MEM_WORDS];
    bit                   saw_full;
    logic [TAG_W-1:0]     d;
    logic [TAG_W-1:0]     p;
    logic [TAG_W-1:0]     prev;

    issue_cluster DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic int pick(input int n);
        return int'(xorshift() % 32'(n));
    endfunction

    function automatic tomasulo_pkg::rv_op_e rand_alu_op();
        int k;
        k = pick(17);
        if (k == 15) return tomasulo_pkg::BLT;
        if (k == 16) return tomasulo_pkg::BLTU;
        return tomasulo_pkg::rv_op_e'(5'(k));
    endfunction

    function automatic logic [XLEN-1:0] alu_model(input tomasulo_pkg::rv_op_e o,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (o)
            tomasulo_pkg::ADD:  return a + b;
            tomasulo_pkg::SUB:  return a - b;
            tomasulo_pkg::AND:  return a & b;
            tomasulo_pkg::OR:   return a | b;
            tomasulo_pkg::XOR:  return a ^ b;
            tomasulo_pkg::SLL:  return a << b[4:0];
            tomasulo_pkg::SRL:  return a >> b[4:0];
            tomasulo_pkg::SRA:  return $signed(a) >>> b[4:0];
            tomasulo_pkg::SLT,
            tomasulo_pkg::BLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            tomasulo_pkg::SLTU,
            tomasulo_pkg::BLTU: return (a < b) ? 32'd1 : 32'd0;
            tomasulo_pkg::BGE:  return ($signed(a) >= $signed(b)) ? 32'd1 : 32'd0;
            tomasulo_pkg::BGEU: return (a >= b) ? 32'd1 : 32'd0;
            tomasulo_pkg::BEQ:  return (a == b) ? 32'd1 : 32'd0;
            tomasulo_pkg::BNE:  return (a != b) ? 32'd1 : 32'd0;
            tomasulo_pkg::LUI:  return b;
            default:            return '0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] load_model(input tomasulo_pkg::rv_op_e o,
                                                   input logic [31:0] addr);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = shadow[addr[7:2]];
        b = w[int'(addr[1:0]) * 8 +: 8];
        h = w[int'(addr[1]) * 16 +: 16];
        case (o)
            tomasulo_pkg::LB:  return {{24{b[7]}}, b};
            tomasulo_pkg::LBU: return {24'b0, b};
            tomasulo_pkg::LH:  return {{16{h[15]}}, h};
            tomasulo_pkg::LHU: return {16'b0, h};
            default:           return w;
        endcase
    endfunction

    task automatic store_model(input tomasulo_pkg::rv_op_e o, input logic [31:0] addr,
                               input logic [31:0] data);
        case (o)
            tomasulo_pkg::SB: shadow[addr[7:2]][int'(addr[1:0]) * 8 +: 8] = data[7:0];
            tomasulo_pkg::SH: shadow[addr[7:2]][int'(addr[1]) * 16 +: 16] = data[15:0];
            default:          shadow[addr[7:2]] = data;
        endcase
    endtask

    task automatic fail_now();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_bus(input logic [TAG_W-1:0] t, input logic [XLEN-1:0] data,
                             input string name);
        if (t != '0) begin
            assert (pend[t]) else begin
                $display("Tag %0d was broadcast on %s while not outstanding", t, name);
                fail_now();
            end
            assert (data == val[t]) else begin
                $display("Error: %s for tag %0h is %h, expected %h", name, t, data, val[t]);
                fail_now();
            end
            if (due[t] >= 0) begin
                assert (cycle == due[t]) else begin
                    $display("Tag %0d arrived in cycle %0d instead of cycle %0d",
                             t, cycle, due[t]);
                    fail_now();
                end
            end
            pend[t] = 1'b0;
        end
    endtask

    // one clock, then look at the buses once they have settled.
    task automatic tick();
        @(posedge clk);
        #1;
        cycle++;
        if (cycle > LIMIT) begin
            $display("Timeout after %0d cycles with results still outstanding", cycle);
            fail_now();
        end
        if (rs_full)
            saw_full = 1'b1;
        bus_alu = alu_des;
        bus_mem = memory_des;
        check_bus(alu_des, alu_data, "alu_data");
        check_bus(memory_des, memory_data, "memory_data");
    endtask

    task automatic idle();
        op = tomasulo_pkg::NOP;
        tick();
    endtask

    task automatic drive(input tomasulo_pkg::rv_op_e o, input logic [TAG_W-1:0] t,
                         input logic [XLEN-1:0] v1, input logic [XLEN-1:0] v2,
                         input logic [XLEN-1:0] im, input logic [TAG_W-1:0] q1,
                         input logic [TAG_W-1:0] q2);
        op     = o;
        des_in = t;
        value1 = v1;
        value2 = v2;
        imm_in = im;
        query1 = q1;
        query2 = q2;
        tick();
    endtask

    // hold off until the station has room and, for results, a tag is free.
    task automatic wait_slot(input bit need_tag, output logic [TAG_W-1:0] t_out);
        bit got;
        got   = 1'b0;
        t_out = '0;
        while (!got) begin
            if (!rs_full) begin
                got = !need_tag;
                for (int t = NTAGS - 1; t >= 1; t--) begin
                    if (!pend[t]) begin
                        t_out = TAG_W'(t);
                        got   = 1'b1;
                    end
                end
            end
            if (!got)
                idle();
        end
        if (!need_tag)
            t_out = TAG_W'(pick(NTAGS - 1) + 1); // stores never broadcast.
    endtask

    // a tag in flight or on a bus right now is named, anything else is passed as value.
    task automatic pick_source(input logic [TAG_W-1:0] t, output logic [TAG_W-1:0] q,
                               output logic [XLEN-1:0] v, output logic [XLEN-1:0] operand);
        v = xorshift();
        if (v[31:30] == 2'b00)
            v = v & 32'h7; // small values so compares hit equality.
        if ((t != '0) && (pend[t] || (t == bus_alu) || (t == bus_mem))) begin
            q       = t;
            operand = val[t];
        end else begin
            q       = '0;
            operand = v;
        end
    endtask

    task automatic send_alu(input tomasulo_pkg::rv_op_e o, input logic [TAG_W-1:0] t1,
                            input logic [TAG_W-1:0] t2, input bit timed,
                            output logic [TAG_W-1:0] t_out);
        logic [TAG_W-1:0] q1;
        logic [TAG_W-1:0] q2;
        logic [XLEN-1:0]  v1;
        logic [XLEN-1:0]  v2;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        wait_slot(1'b1, t_out);
        pick_source(t1, q1, v1, a);
        pick_source(t2, q2, v2, b);
        val[t_out]  = alu_model(o, a, b);
        pend[t_out] = 1'b1;
        due[t_out]  = timed ? cycle + 4 : -1; // sampled next edge, broadcast three later.
        drive(o, t_out, v1, v2, xorshift(), q1, q2);
    endtask

    task automatic send_mem(input tomasulo_pkg::rv_op_e o, output logic [TAG_W-1:0] t_out);
        logic [31:0] addr;
        logic [31:0] base;
        logic [31:0] data;
        bit          is_store;
        is_store = o inside {tomasulo_pkg::SB, tomasulo_pkg::SH, tomasulo_pkg::SW};
        wait_slot(!is_store, t_out);
        addr = xorshift();
        if (o inside {tomasulo_pkg::LH, tomasulo_pkg::LHU, tomasulo_pkg::SH})
            addr[0] = 1'b0;
        else if (o inside {tomasulo_pkg::LW, tomasulo_pkg::SW})
            addr[1:0] = 2'b00;
        base = xorshift();
        data = xorshift();
        if (is_store) begin
            store_model(o, addr, data);
        end else begin
            val[t_out]  = load_model(o, addr);
            pend[t_out] = 1'b1;
            due[t_out]  = -1;
        end
        drive(o, t_out, base, data, addr - base, '0, '0);
    endtask

    task automatic drain();
        bit waiting;
        waiting = 1'b1;
        while (waiting) begin
            idle();
            waiting = 1'b0;
            for (int t = 1; t < NTAGS; t++)
                waiting = waiting | pend[t];
        end
    endtask

    initial begin
        seed     = 32'hab64;
        cycle    = 0;
        saw_full = 1'b0;
        bus_alu  = '0;
        bus_mem  = '0;
        for (int t = 0; t < NTAGS; t++) begin
            pend[t] = 1'b0;
            val[t]  = '0;
            due[t]  = -1;
        end
        for (int w = 0; w < `TOMASULO_MEM_WORDS; w++)
            shadow[w] = '0;
        op     = tomasulo_pkg::NOP;
        des_in = '0;
        value1 = '0;
        value2 = '0;
        imm_in = '0;
        query1 = '0;
        query2 = '0;
        rst    = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;
        assert (rs_full == 1'b0 && alu_des == '0 && memory_des == '0) else begin
            $display("Error: after reset rs_full=%h alu_des=%h memory_des=%h",
                     rs_full, alu_des, memory_des);
            fail_now();
        end

        // independent ops, fixed latency.
        repeat (N_ALU) send_alu(rand_alu_op(), '0, '0, 1'b1, d);
        drain();

        // sources name recent or random tags.
        prev = '0;
        repeat (N_CHAIN) begin
            send_alu(rand_alu_op(), (pick(2) == 0) ? prev : TAG_W'(pick(NTAGS)),
                     TAG_W'(pick(NTAGS)), 1'b0, d);
            prev = d;
        end
        drain();

        repeat (N_MEM) send_mem(tomasulo_pkg::rv_op_e'(5'(23 + pick(3))), d);
        repeat (10) idle(); // let every store reach memory.
        repeat (N_MEM) send_mem(tomasulo_pkg::rv_op_e'(5'(18 + pick(5))), d);
        drain();

        // chained bursts behind a load fill the station.
        saw_full = 1'b0;
        repeat (N_BURST) begin
            send_mem(tomasulo_pkg::LW, p);
            prev = p;
            repeat (BURST_LEN) begin
                send_alu(rand_alu_op(), p, prev, 1'b0, d);
                prev = d;
            end
        end
        drain();
        assert (saw_full) else begin
            $display("rs_full never went high during the dependent bursts");
            fail_now();
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- testbench/issue_cluster_props.sv
`timescale 1ns/100ps
`include "tomasulo_cfg.svh"

module issue_cluster_props (
    input  logic                          clk,
    input  logic                          rst,
    input  tomasulo_pkg::rv_op_e          alu_op,
    input  logic [`TOMASULO_TAG_W-1:0]    alu_des_issue,
    input  tomasulo_pkg::rv_op_e          memory_op,
    input  logic [`TOMASULO_TAG_W-1:0]    memory_des_issue,
    input  logic                          rs_full,
    input  logic [`TOMASULO_TAG_W-1:0]    alu_des,
    input  logic [`TOMASULO_TAG_W-1:0]    memory_des
);
    // an issued op always names the tag it will broadcast.
    alu_issue_tag: assert property (@(posedge clk) disable iff (!rst)
        (alu_op != tomasulo_pkg::NOP) |-> (alu_des_issue != '0))
        else $error("alu issue port carries a valid op with tag 0");

    mem_issue_tag: assert property (@(posedge clk) disable iff (!rst)
        (memory_op != tomasulo_pkg::NOP) |-> (memory_des_issue != '0))
        else $error("memory issue port carries a valid op with tag 0");

    full_after_reset: assert property (@(posedge clk) $rose(rst) |=> !rs_full)
        else $error("rs_full set in the cycle after reset");

    distinct_tags: assert property (@(posedge clk) disable iff (!rst)
        !((alu_des != '0) && (alu_des == memory_des)))
        else $error("both broadcast buses carry the same tag");

endmodule

bind reservation_station issue_cluster_props props (
    .clk(clk), .rst(rst), .alu_op(alu_op), .alu_des_issue(alu_des_issue),
    .memory_op(memory_op), .memory_des_issue(memory_des_issue), .rs_full(rs_full),
    .alu_des(alu_des), .memory_des(memory_des)
);

//--- logic/issue_cluster.sv
`timescale 1ns/100ps
`include "tomasulo_cfg.svh"

module issue_cluster (
    input  logic                          clk,
    input  logic                          rst,
    input  tomasulo_pkg::rv_op_e          op,
    input  logic [`TOMASULO_TAG_W-1:0]    des_in,
    input  logic [`TOMASULO_XLEN-1:0]     value1,
    input  logic [`TOMASULO_XLEN-1:0]     value2,
    input  logic [`TOMASULO_XLEN-1:0]     imm_in,
    input  logic [`TOMASULO_TAG_W-1:0]    query1,
    input  logic [`TOMASULO_TAG_W-1:0]    query2,
    output logic                          rs_full,
    output logic [`TOMASULO_TAG_W-1:0]    alu_des,
    output logic [`TOMASULO_XLEN-1:0]     alu_data,
    output logic [`TOMASULO_TAG_W-1:0]    memory_des,
    output logic [`TOMASULO_XLEN-1:0]     memory_data
);
    // issue ports between the station and the units.
    tomasulo_pkg::rv_op_e          alu_op;
    logic [`TOMASULO_XLEN-1:0]     alu_value1;
    logic [`TOMASULO_XLEN-1:0]     alu_value2;
    logic [`TOMASULO_TAG_W-1:0]    alu_des_issue;
    tomasulo_pkg::rv_op_e          memory_op;
    logic [`TOMASULO_XLEN-1:0]     memory_value1;
    logic [`TOMASULO_XLEN-1:0]     memory_value2;
    logic [`TOMASULO_XLEN-1:0]     memory_imm;
    logic [`TOMASULO_TAG_W-1:0]    memory_des_issue;

    reservation_station u_rs (.*);

    exec_alu u_alu (.*);

    load_store_unit u_lsu (.*);

endmodule

//--- logic/load_store_unit.sv
`timescale 1ns/100ps
`include "tomasulo_cfg.svh"

module load_store_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  tomasulo_pkg::rv_op_e          memory_op,
    input  logic [`TOMASULO_XLEN-1:0]     memory_value1,
    input  logic [`TOMASULO_XLEN-1:0]     memory_value2,
    input  logic [`TOMASULO_XLEN-1:0]     memory_imm,
    input  logic [`TOMASULO_TAG_W-1:0]    memory_des_issue,
    output logic [`TOMASULO_TAG_W-1:0]    memory_des,
    output logic [`TOMASULO_XLEN-1:0]     memory_data
);
    localparam int XLEN      = `TOMASULO_XLEN;
    localparam int MEM_WORDS = `TOMASULO_MEM_WORDS;
    localparam int AW        = $clog2(MEM_WORDS);

    logic [XLEN-1:0]         mem [MEM_WORDS];
    logic [XLEN-1:0]         addr;
    logic [AW-1:0]           idx;
    tomasulo_pkg::mem_word_u cur;
    tomasulo_pkg::mem_word_u merged;
    logic [7:0]              byte_lane;
    logic [XLEN/2-1:0]       half_lane;
    logic [XLEN-1:0]         load_val;
    logic                    is_load;
    logic                    is_store;

    assign addr     = memory_value1 + memory_imm;
    assign idx      = addr[AW+1:2]; // word address.
    assign cur.word = mem[idx];

    assign is_load  = memory_op inside {tomasulo_pkg::LB, tomasulo_pkg::LH, tomasulo_pkg::LW,
                                        tomasulo_pkg::LBU, tomasulo_pkg::LHU};
    assign is_store = memory_op inside {tomasulo_pkg::SB, tomasulo_pkg::SH, tomasulo_pkg::SW};

    assign byte_lane = cur.bytes[addr[1:0]];
    assign half_lane = cur.half[addr[1]];

    always_comb begin
        case (memory_op)
            tomasulo_pkg::LB:  load_val = {{(XLEN-8){byte_lane[7]}}, byte_lane};
            tomasulo_pkg::LBU: load_val = {{(XLEN-8){1'b0}}, byte_lane};
            tomasulo_pkg::LH:  load_val = {{(XLEN/2){half_lane[XLEN/2-1]}}, half_lane};
            tomasulo_pkg::LHU: load_val = {{(XLEN/2){1'b0}}, half_lane};
            default:           load_val = cur.word;
        endcase
    end

    // read-modify-write, only the addressed lane changes.
    always_comb begin
        merged = cur;
        case (memory_op)
            tomasulo_pkg::SB: merged.bytes[addr[1:0]] = memory_value2[7:0];
            tomasulo_pkg::SH: merged.half[addr[1]]    = memory_value2[XLEN/2-1:0];
            tomasulo_pkg::SW: merged.word             = memory_value2;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= '0;
            memory_des <= '0;
        end else begin
            if (is_store)
                mem[idx] <= merged.word;
            memory_des <= is_load ? memory_des_issue : '0; // stores stay silent.
        end
    end

    always_ff @(posedge clk) begin
        memory_data <= load_val;
    end

endmodule

//--- logic/exec_alu.sv
`timescale 1ns/100ps
`include "tomasulo_cfg.svh"

module exec_alu (
    input  logic                          clk,
    input  logic                          rst,
    input  tomasulo_pkg::rv_op_e          alu_op,
    input  logic [`TOMASULO_XLEN-1:0]     alu_value1,
    input  logic [`TOMASULO_XLEN-1:0]     alu_value2,
    input  logic [`TOMASULO_TAG_W-1:0]    alu_des_issue,
    output logic [`TOMASULO_TAG_W-1:0]    alu_des,
    output logic [`TOMASULO_XLEN-1:0]     alu_data
);
    localparam int XLEN = `TOMASULO_XLEN;

    logic [4:0]      shamt;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] result;

    assign shamt = alu_value2[4:0];
    assign eq    = (alu_value1 == alu_value2);
    assign lt_s  = ($signed(alu_value1) < $signed(alu_value2));
    assign lt_u  = (alu_value1 < alu_value2);

    always_comb begin
        case (alu_op)
            tomasulo_pkg::ADD:  result = alu_value1 + alu_value2;
            tomasulo_pkg::SUB:  result = alu_value1 - alu_value2;
            tomasulo_pkg::AND:  result = alu_value1 & alu_value2;
            tomasulo_pkg::OR:   result = alu_value1 | alu_value2;
            tomasulo_pkg::XOR:  result = alu_value1 ^ alu_value2;
            tomasulo_pkg::SLL:  result = alu_value1 << shamt;
            tomasulo_pkg::SRL:  result = alu_value1 >> shamt;
            tomasulo_pkg::SRA:  result = $signed(alu_value1) >>> shamt;
            tomasulo_pkg::SLT:  result = XLEN'(lt_s);
            tomasulo_pkg::SLTU: result = XLEN'(lt_u);
            tomasulo_pkg::LUI:  result = alu_value2; // upper immediate comes in ready.
            // branches only report the condition.
            tomasulo_pkg::BEQ:  result = XLEN'(eq);
            tomasulo_pkg::BNE:  result = XLEN'(!eq);
            tomasulo_pkg::BLT:  result = XLEN'(lt_s);
            tomasulo_pkg::BGE:  result = XLEN'(!lt_s);
            tomasulo_pkg::BLTU: result = XLEN'(lt_u);
            tomasulo_pkg::BGEU: result = XLEN'(!lt_u);
            default:            result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst)
            alu_des <= '0;
        else
            alu_des <= (alu_op != tomasulo_pkg::NOP) ? alu_des_issue : '0;
    end

    always_ff @(posedge clk) begin
        alu_data <= result;
    end

endmodule

//--- logic/reservation_station.sv
`timescale 1ns/100ps
`include "tomasulo_cfg.svh"

module reservation_station (
    input  logic                          clk,
    input  logic                          rst,
    input  tomasulo_pkg::rv_op_e          op,
    input  logic [`TOMASULO_TAG_W-1:0]    des_in,
    input  logic [`TOMASULO_XLEN-1:0]     value1,
    input  logic [`TOMASULO_XLEN-1:0]     value2,
    input  logic [`TOMASULO_XLEN-1:0]     imm_in,
    input  logic [`TOMASULO_TAG_W-1:0]    query1,
    input  logic [`TOMASULO_TAG_W-1:0]    query2,
    input  logic [`TOMASULO_TAG_W-1:0]    alu_des,
    input  logic [`TOMASULO_XLEN-1:0]     alu_data,
    input  logic [`TOMASULO_TAG_W-1:0]    memory_des,
    input  logic [`TOMASULO_XLEN-1:0]     memory_data,
    output tomasulo_pkg::rv_op_e          alu_op,
    output logic [`TOMASULO_XLEN-1:0]     alu_value1,
    output logic [`TOMASULO_XLEN-1:0]     alu_value2,
    output logic [`TOMASULO_TAG_W-1:0]    alu_des_issue,
    output tomasulo_pkg::rv_op_e          memory_op,
    output logic [`TOMASULO_XLEN-1:0]     memory_value1,
    output logic [`TOMASULO_XLEN-1:0]     memory_value2,
    output logic [`TOMASULO_XLEN-1:0]     memory_imm,
    output logic [`TOMASULO_TAG_W-1:0]    memory_des_issue,
    output logic                          rs_full
);
    localparam int XLEN    = `TOMASULO_XLEN;
    localparam int TAG_W   = `TOMASULO_TAG_W;
    localparam int SLOTS   = `TOMASULO_SLOTS;
    localparam int ENTRIES = 2 * SLOTS; // alu entries first, then memory.
    localparam int IDX_W   = $clog2(ENTRIES);

    // dispatch stage, one op in flight toward the entries.
    logic                 d_valid;
    tomasulo_pkg::rv_op_e d_op;
    logic [TAG_W-1:0]     d_des;
    logic [XLEN-1:0]      d_v1;
    logic [XLEN-1:0]      d_v2;
    logic [TAG_W-1:0]     d_q1;
    logic [TAG_W-1:0]     d_q2;
    logic [XLEN-1:0]      d_imm;
    logic                 d_is_mem;

    logic [ENTRIES-1:0]   busy;
    tomasulo_pkg::rv_op_e e_op  [ENTRIES];
    logic [TAG_W-1:0]     e_des [ENTRIES];
    logic [XLEN-1:0]      e_v1  [ENTRIES];
    logic [XLEN-1:0]      e_v2  [ENTRIES];
    logic [TAG_W-1:0]     e_q1  [ENTRIES];
    logic [TAG_W-1:0]     e_q2  [ENTRIES];
    logic [XLEN-1:0]      e_imm [ENTRIES];

    logic [ENTRIES-1:0]   ready;
    logic                 alu_go;
    logic                 mem_go;
    logic [IDX_W-1:0]     alu_sel;
    logic [IDX_W-1:0]     mem_sel;
    logic                 wr_hit;
    logic [IDX_W-1:0]     wr_idx;
    int                   alu_next;
    int                   mem_next;

    function automatic logic is_mem(input tomasulo_pkg::rv_op_e o);
        return (o >= tomasulo_pkg::LB) && (o <= tomasulo_pkg::SW);
    endfunction

    // value seen by a source this cycle, with bypass from either bus.
    function automatic logic [XLEN-1:0] fwd_value(input logic [TAG_W-1:0] q,
                                                  input logic [XLEN-1:0] v);
        if (q == '0)
            return v;
        else if (q == alu_des)
            return alu_data;
        else if (q == memory_des)
            return memory_data;
        return v;
    endfunction

    function automatic logic [TAG_W-1:0] fwd_tag(input logic [TAG_W-1:0] q);
        return ((q == alu_des) || (q == memory_des)) ? '0 : q;
    endfunction

    assign d_is_mem = is_mem(d_op);

    always_comb begin
        for (int i = 0; i < ENTRIES; i++)
            ready[i] = busy[i] && (e_q1[i] == '0) && (e_q2[i] == '0);
    end

    // lowest ready entry of each class wins.
    always_comb begin
        alu_go  = 1'b0;
        alu_sel = '0;
        mem_go  = 1'b0;
        mem_sel = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (ready[i]) begin
                alu_go  = 1'b1;
                alu_sel = IDX_W'(i);
            end
        end
        for (int i = ENTRIES - 1; i >= SLOTS; i--) begin
            if (ready[i]) begin
                mem_go  = 1'b1;
                mem_sel = IDX_W'(i);
            end
        end
    end

    always_comb begin
        wr_hit = 1'b0;
        wr_idx = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (!busy[i] && ((i >= SLOTS) == d_is_mem)) begin
                wr_hit = 1'b1;
                wr_idx = IDX_W'(i);
            end
        end
    end

    // busy count per class after this edge.
    always_comb begin
        alu_next = $countones(busy[SLOTS-1:0]) - int'(alu_go) + int'(d_valid && !d_is_mem);
        mem_next = $countones(busy[ENTRIES-1:SLOTS]) - int'(mem_go) + int'(d_valid && d_is_mem);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            d_valid          <= 1'b0;
            busy             <= '0;
            rs_full          <= 1'b0;
            alu_op           <= tomasulo_pkg::NOP;
            alu_des_issue    <= '0;
            memory_op        <= tomasulo_pkg::NOP;
            memory_des_issue <= '0;
        end else begin
            d_valid <= (op != tomasulo_pkg::NOP);
            if (alu_go)
                busy[alu_sel] <= 1'b0;
            if (mem_go)
                busy[mem_sel] <= 1'b0;
            if (d_valid && wr_hit)
                busy[wr_idx] <= 1'b1; // no free entry drops the op.
            rs_full          <= (alu_next >= 2) || (mem_next >= 2);
            alu_op           <= alu_go ? e_op[alu_sel] : tomasulo_pkg::NOP;
            alu_des_issue    <= alu_go ? e_des[alu_sel] : '0;
            memory_op        <= mem_go ? e_op[mem_sel] : tomasulo_pkg::NOP;
            memory_des_issue <= mem_go ? e_des[mem_sel] : '0;
        end
    end

    always_ff @(posedge clk) begin
        d_op  <= op;
        d_des <= des_in;
        d_v1  <= fwd_value(query1, value1);
        d_q1  <= fwd_tag(query1);
        d_v2  <= fwd_value(query2, value2);
        d_q2  <= fwd_tag(query2);
        d_imm <= imm_in;
        for (int i = 0; i < ENTRIES; i++) begin
            if (d_valid && wr_hit && (wr_idx == IDX_W'(i))) begin
                e_op[i]  <= d_op;
                e_des[i] <= d_des;
                e_v1[i]  <= fwd_value(d_q1, d_v1);
                e_q1[i]  <= fwd_tag(d_q1);
                e_v2[i]  <= fwd_value(d_q2, d_v2);
                e_q2[i]  <= fwd_tag(d_q2);
                e_imm[i] <= d_imm;
            end else begin
                e_v1[i] <= fwd_value(e_q1[i], e_v1[i]); // wakeup.
                e_q1[i] <= fwd_tag(e_q1[i]);
                e_v2[i] <= fwd_value(e_q2[i], e_v2[i]);
                e_q2[i] <= fwd_tag(e_q2[i]);
            end
        end
        alu_value1    <= e_v1[alu_sel];
        alu_value2    <= e_v2[alu_sel];
        memory_value1 <= e_v1[mem_sel];
        memory_value2 <= e_v2[mem_sel];
        memory_imm    <= e_imm[mem_sel];
    end

endmodule

//--- logic/tomasulo_pkg.sv
`include "tomasulo_cfg.svh"

package tomasulo_pkg;

    // operation codes as presented by the decoder.
    typedef enum logic [4:0] {
        ADD  = 5'd0,
        AND  = 5'd1,
        OR   = 5'd2,
        SLL  = 5'd3,
        SRL  = 5'd4,
        SLT  = 5'd5,
        SLTU = 5'd6,
        SRA  = 5'd7,
        SUB  = 5'd8,
        XOR  = 5'd9,
        BEQ  = 5'd10,
        BGE  = 5'd11,
        BNE  = 5'd12,
        BGEU = 5'd13,
        LUI  = 5'd14,
        LB   = 5'd18, // memory class starts here.
        LH   = 5'd19,
        LW   = 5'd20,
        LBU  = 5'd21,
        LHU  = 5'd22,
        SB   = 5'd23,
        SH   = 5'd24,
        SW   = 5'd25, // ... and ends here.
        BLT  = 5'd26,
        BLTU = 5'd27,
        NOP  = 5'd31
    } rv_op_e;

    // one memory word seen whole, as halfwords or as bytes.
    typedef union packed {
        logic [`TOMASULO_XLEN-1:0]                word;
        logic [1:0][`TOMASULO_XLEN/2-1:0]         half;
        logic [`TOMASULO_XLEN/8-1:0][7:0]         bytes;
    } mem_word_u;

endpackage

//--- include/tomasulo_cfg.svh
`ifndef TOMASULO_CFG_SVH
`define TOMASULO_CFG_SVH

// data path word width.
`define TOMASULO_XLEN 32
// result tag width, tag 0 means no pending producer.
`define TOMASULO_TAG_W 3
// entries per class.
`define TOMASULO_SLOTS 3
// data memory depth in words.
`define TOMASULO_MEM_WORDS 64

`endif
